// File: compile.f
hdl/pkt_fmt_pkg.sv
hdl/queue_pkg.sv
hdl/class_queue_if.sv
hdl/pkt_fifo.sv
hdl/class_queue.sv
hdl/egress_scheduler.sv
hdl/egress_top.sv
testbench/egress_checker.sv
testbench/tb_egress.sv

// File: hdl/class_queue.sv
`timescale 1ns/1ps

module class_queue (
    input  logic               i_sys_clk,
    input  logic               i_sys_rst_n,
    input  pkt_fmt_pkg::beat_t i_beat,
    input  logic               i_beat_en,
    input  pkt_fmt_pkg::desc_t i_desc,
    input  logic               i_desc_en,
    output logic               o_afull,             // beat store almost full
    class_queue_if.queue       q
);

    pkt_fifo #(
        .payload_t (pkt_fmt_pkg::beat_t),
        .DEPTH     (queue_pkg::BEAT_DEPTH),
        .CNT_W     (queue_pkg::BEAT_CNT_W)
    ) u_beat_fifo (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .i_wr        (i_beat_en),
        .i_wr_data   (i_beat),
        .i_rd        (q.beat_pop),
        .o_head      (q.beat_head),
        .o_empty     (q.beat_empty),
        .o_afull     (o_afull)
    );

    pkt_fifo #(
        .payload_t (pkt_fmt_pkg::desc_t),
        .DEPTH     (queue_pkg::DESC_DEPTH),
        .CNT_W     (queue_pkg::DESC_CNT_W)
    ) u_desc_fifo (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .i_wr        (i_desc_en),
        .i_wr_data   (i_desc),
        .i_rd        (q.desc_pop),
        .o_head      (q.desc_head),
        .o_empty     (q.desc_empty),
        .o_afull     ()
    );

    // descriptor only follows a complete frame, so its head beat is waiting
    a_desc_on_head: assert property (
        @(posedge i_sys_clk) disable iff (!i_sys_rst_n)
        q.desc_pop |-> !q.beat_empty && q.beat_head.tag == pkt_fmt_pkg::TAG_HEAD
    );

endmodule

// File: hdl/class_queue_if.sv
`timescale 1ns/1ps

// read side of one class queue, seen by the scheduler
interface class_queue_if;

    pkt_fmt_pkg::beat_t beat_head;                  // oldest beat
    logic               beat_empty;
    pkt_fmt_pkg::desc_t desc_head;                  // oldest descriptor
    logic               desc_empty;
    logic               beat_pop;                   // plain strobe
    logic               desc_pop;

    modport queue (
        output beat_head,
        output beat_empty,
        output desc_head,
        output desc_empty,
        input  beat_pop,
        input  desc_pop
    );

    modport sched (
        input  beat_head,
        input  beat_empty,
        input  desc_head,
        input  desc_empty,
        output beat_pop,
        output desc_pop
    );

endinterface

// File: hdl/egress_scheduler.sv
`timescale 1ns/1ps

module egress_scheduler (
    input  logic               i_sys_clk,
    input  logic               i_sys_rst_n,
    class_queue_if.sched       ts,
    class_queue_if.sched       be,
    input  logic               i_pkt_data_alf,      // downstream almost full
    output pkt_fmt_pkg::beat_t o_pkt_data,
    output logic               o_pkt_data_en,
    output pkt_fmt_pkg::desc_t o_pkt_val,
    output logic               o_pkt_val_en
);

    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        TS_SEND = 5'b00010,
        BE_SEND = 5'b00100,
        TS_DROP = 5'b01000,
        BE_DROP = 5'b10000
    } state_t;

    state_t             state;
    state_t             state_nxt;
    pkt_fmt_pkg::beat_t sel_head;
    logic               sel_tail;
    logic               ts_act;
    logic               be_act;
    logic               send_pop;
    pkt_fmt_pkg::desc_t desc_q;                     // held from frame start to tail

    assign ts_act   = (state == TS_SEND) || (state == TS_DROP);
    assign be_act   = (state == BE_SEND) || (state == BE_DROP);
    assign sel_head = ts_act ? ts.beat_head : be.beat_head;
    assign sel_tail = sel_head[pkt_fmt_pkg::TAIL_BIT];

    // one beat per cycle, forwarded or thrown away
    assign ts.beat_pop = ts_act & ~ts.beat_empty;
    assign be.beat_pop = be_act & ~be.beat_empty;
    assign send_pop    = (state == TS_SEND && ts.beat_pop) ||
                         (state == BE_SEND && be.beat_pop);

    always_comb begin
        state_nxt   = state;
        ts.desc_pop = 1'b0;
        be.desc_pop = 1'b0;
        case (state)
            IDLE: begin
                if (!ts.desc_empty) begin
                    if (!ts.desc_head.valid) begin
                        ts.desc_pop = 1'b1;
                        state_nxt   = TS_DROP;
                    end else if (!i_pkt_data_alf) begin
                        ts.desc_pop = 1'b1;
                        state_nxt   = TS_SEND;
                    end
                    // valid ts under back-pressure holds everything off
                end else if (!be.desc_empty) begin
                    be.desc_pop = 1'b1;
                    if (be.desc_head.valid && !i_pkt_data_alf) begin
                        state_nxt = BE_SEND;
                    end else begin
                        state_nxt = BE_DROP;        // invalid or no room downstream
                    end
                end
            end
            TS_SEND, BE_SEND, TS_DROP, BE_DROP: begin
                if ((ts.beat_pop || be.beat_pop) && sel_tail) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
        if (!i_sys_rst_n) begin
            state         <= IDLE;
            o_pkt_data_en <= 1'b0;
            o_pkt_val_en  <= 1'b0;
        end else begin
            state         <= state_nxt;
            o_pkt_data_en <= send_pop;
            o_pkt_val_en  <= send_pop & sel_tail;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (ts.desc_pop) begin
            desc_q <= ts.desc_head;
        end else if (be.desc_pop) begin
            desc_q <= be.desc_head;
        end
        if (send_pop) begin
            o_pkt_data <= sel_head;
        end
        if (send_pop && sel_tail) begin
            o_pkt_val <= desc_q;                    // descriptor rides with the tail
        end
    end

    // descriptor only on a tail beat, and a gap before the next frame
    a_val_on_tail: assert property (
        @(posedge i_sys_clk) disable iff (!i_sys_rst_n)
        o_pkt_val_en |-> o_pkt_data_en && o_pkt_data.tag == pkt_fmt_pkg::TAG_TAIL
                         ##1 !o_pkt_data_en
    );

endmodule

// File: hdl/egress_top.sv
`timescale 1ns/1ps

module egress_top (
    input  logic                           i_sys_clk,
    input  logic                           i_sys_rst_n,

    input  logic [pkt_fmt_pkg::BEAT_W-1:0] i_ts_pkt_data,     // tag, valid bytes, data
    input  logic                           i_ts_pkt_data_en,
    input  logic [pkt_fmt_pkg::DESC_W-1:0] i_ts_pkt_val,      // valid flag, length
    input  logic                           i_ts_pkt_val_en,
    output logic                           o_ts_pkt_data_alf,

    input  logic [pkt_fmt_pkg::BEAT_W-1:0] i_be_pkt_data,
    input  logic                           i_be_pkt_data_en,
    input  logic [pkt_fmt_pkg::DESC_W-1:0] i_be_pkt_val,
    input  logic                           i_be_pkt_val_en,
    output logic                           o_be_pkt_data_alf,

    output logic [pkt_fmt_pkg::BEAT_W-1:0] o_pkt_data,
    output logic                           o_pkt_data_en,
    output logic [pkt_fmt_pkg::DESC_W-1:0] o_pkt_val,
    output logic                           o_pkt_val_en,      // with the tail beat
    input  logic                           i_pkt_data_alf
);

    class_queue_if ts_q ();
    class_queue_if be_q ();

    class_queue u_ts_queue (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .i_beat      (i_ts_pkt_data),
        .i_beat_en   (i_ts_pkt_data_en),
        .i_desc      (i_ts_pkt_val),
        .i_desc_en   (i_ts_pkt_val_en),
        .o_afull     (o_ts_pkt_data_alf),
        .q           (ts_q.queue)
    );

    class_queue u_be_queue (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .i_beat      (i_be_pkt_data),
        .i_beat_en   (i_be_pkt_data_en),
        .i_desc      (i_be_pkt_val),
        .i_desc_en   (i_be_pkt_val_en),
        .o_afull     (o_be_pkt_data_alf),
        .q           (be_q.queue)
    );

    // ts has strict priority
    egress_scheduler u_scheduler (
        .i_sys_clk      (i_sys_clk),
        .i_sys_rst_n    (i_sys_rst_n),
        .ts             (ts_q.sched),
        .be             (be_q.sched),
        .i_pkt_data_alf (i_pkt_data_alf),
        .o_pkt_data     (o_pkt_data),
        .o_pkt_data_en  (o_pkt_data_en),
        .o_pkt_val      (o_pkt_val),
        .o_pkt_val_en   (o_pkt_val_en)
    );

endmodule

// File: hdl/pkt_fifo.sv
`timescale 1ns/1ps

module pkt_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16,                  // power of two
    parameter int  CNT_W     = $clog2(DEPTH) + 1
) (
    input  logic     i_sys_clk,
    input  logic     i_sys_rst_n,
    input  logic     i_wr,
    input  payload_t i_wr_data,
    input  logic     i_rd,
    output payload_t o_head,
    output logic     o_empty,
    output logic     o_afull
);

    localparam int PTR_W    = $clog2(DEPTH);
    localparam int AF_LEVEL = queue_pkg::BEAT_AF_LEVEL * DEPTH / queue_pkg::BEAT_DEPTH;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge i_sys_clk) begin
        if (i_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
        if (!i_sys_rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            o_afull <= 1'b0;
        end else begin
            if (i_wr) begin
                wr_ptr <= wr_ptr + 1'b1;            // wraps at DEPTH
            end
            if (i_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count   <= count + CNT_W'(i_wr) - CNT_W'(i_rd);
            o_afull <= (count >= CNT_W'(AF_LEVEL)); // lags the count by one cycle
        end
    end

    // show-ahead, oldest entry always on the head
    assign o_head  = mem[rd_ptr];
    assign o_empty = (count == '0);

    // upstream must stop on almost-full long before this
    a_no_overflow: assert property (
        @(posedge i_sys_clk) disable iff (!i_sys_rst_n)
        i_wr && !i_rd |-> count < CNT_W'(DEPTH)
    );

    // reader side must watch the empty flag
    a_no_underflow: assert property (
        @(posedge i_sys_clk) disable iff (!i_sys_rst_n)
        i_rd |-> count != '0
    );

endmodule

// File: hdl/pkt_fmt_pkg.sv
package pkt_fmt_pkg;

    localparam int BEAT_W   = 36;
    localparam int DESC_W   = 16;
    localparam int DATA_W   = 32;
    localparam int TAIL_BIT = 34;                   // low tag bit within a beat

    typedef enum logic [1:0] {
        TAG_BODY = 2'b00,
        TAG_TAIL = 2'b01,
        TAG_HEAD = 2'b10
    } beat_tag_t;

    // one word on the data path
    typedef struct packed {
        beat_tag_t         tag;                     // head / body / tail
        logic [1:0]        vbytes;                  // valid bytes in last word
        logic [DATA_W-1:0] data;
    } beat_t;

    // frame descriptor, written after the tail
    typedef struct packed {
        logic        valid;                         // clear means drop
        logic [14:0] len;                           // frame length in bytes
    } desc_t;

endpackage

// File: hdl/queue_pkg.sv
package queue_pkg;

    localparam int BEAT_DEPTH    = 64;
    localparam int DESC_DEPTH    = 16;

    // upper half of the beat store in use
    localparam int BEAT_AF_LEVEL = 32;

    // one extra bit so a full store is countable
    localparam int BEAT_CNT_W    = $clog2(BEAT_DEPTH) + 1;
    localparam int DESC_CNT_W    = $clog2(DESC_DEPTH) + 1;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the egress testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_egress
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_egress | tee sim.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: testbench/egress_checker.sv
`timescale 1ns/1ps

module egress_checker (
    input  logic               i_sys_clk,
    input  logic               i_sys_rst_n,
    input  pkt_fmt_pkg::beat_t i_pkt_data,
    input  logic               i_pkt_data_en,
    input  pkt_fmt_pkg::desc_t i_pkt_val,
    input  logic               i_pkt_val_en,
    output int                 o_errors
);

    pkt_fmt_pkg::beat_t             beat_q [$];            // expected beats, oldest first
    string                          beat_name_q [$];
    logic [pkt_fmt_pkg::DESC_W-1:0] desc_q [$];
    string                          desc_name_q [$];
    logic                           exp_tail;              // expected beat closes its frame
    int                             errors = 0;

    assign o_errors = errors;

    task automatic expect_beat(input string name, input pkt_fmt_pkg::beat_t beat);
        beat_q.push_back(beat);
        beat_name_q.push_back(name);
    endtask

    task automatic expect_desc(input string name, input logic [pkt_fmt_pkg::DESC_W-1:0] desc);
        desc_q.push_back(desc);
        desc_name_q.push_back(name);
    endtask

    function automatic int pending_frames();
        return desc_q.size();
    endfunction

    // outputs are registered, so the falling edge sees them settled
    always @(negedge i_sys_clk) begin
        if (i_sys_rst_n && i_pkt_data_en) begin
            if (beat_q.size() == 0) begin
                $display("unexpected beat 0x%09h on the output port", i_pkt_data);
                errors++;
            end else begin
                if (i_pkt_data !== beat_q[0]) begin
                    $display("FAILED %s beat: expected 0x%09h actual 0x%09h",
                             beat_name_q[0], beat_q[0], i_pkt_data);
                    errors++;
                end
                exp_tail = (beat_q[0].tag == pkt_fmt_pkg::TAG_TAIL);
                if (i_pkt_val_en !== exp_tail) begin
                    $display("FAILED %s descriptor strobe: expected %0b actual %0b",
                             beat_name_q[0], exp_tail, i_pkt_val_en);
                    errors++;
                end
                void'(beat_q.pop_front());
                void'(beat_name_q.pop_front());
            end
        end
        if (i_sys_rst_n && i_pkt_val_en && !i_pkt_data_en) begin
            $display("descriptor strobe came without an output beat");
            errors++;
        end
        if (i_sys_rst_n && i_pkt_val_en) begin
            if (desc_q.size() == 0) begin
                $display("unexpected descriptor 0x%04h on the output port", i_pkt_val);
                errors++;
            end else begin
                if (i_pkt_val !== desc_q[0]) begin
                    $display("FAILED %s descriptor: expected 0x%04h actual 0x%04h",
                             desc_name_q[0], desc_q[0], i_pkt_val);
                    errors++;
                end
                void'(desc_q.pop_front());
                void'(desc_name_q.pop_front());
            end
        end
    end

    task automatic finish_check();
        if (beat_q.size() != 0 || desc_q.size() != 0) begin
            $display("missing frame: %0d beats and %0d descriptors never came out",
                     beat_q.size(), desc_q.size());
            errors++;
        end
    endtask

endmodule

// File: testbench/tb_egress.sv
`timescale 1ns/1ps

module tb_egress;

    localparam int NROWS    = 10;
    localparam int HOLD_CYC = 20;                          // cycles a ts frame is held back
    localparam int TS       = 0;
    localparam int BE       = 1;

    // stimulus columns, then the expected forward decision
    string tbl_name  [NROWS] = '{"ts_single", "be_single", "ts_invalid", "be_after_drop",
                                 "be_invalid", "prio_be", "prio_ts", "bp_be", "bp_ts",
                                 "afull_ts"};
    int    tbl_cls   [NROWS] = '{TS, BE, TS, BE, BE, BE, TS, BE, TS, TS};
    int    tbl_beats [NROWS] = '{4, 5, 3, 4, 2, 3, 4, 4, 4, 40};
    bit    tbl_valid [NROWS] = '{1, 1, 0, 1, 0, 1, 1, 1, 1, 1};
    bit    tbl_hold  [NROWS] = '{0, 0, 0, 0, 0, 1, 0, 0, 0, 0};
    bit    tbl_alf   [NROWS] = '{0, 0, 0, 0, 0, 0, 0, 1, 1, 1};
    bit    tbl_fwd   [NROWS] = '{1, 1, 0, 1, 0, 1, 1, 0, 1, 1};

    logic               sys_clk;
    logic               sys_rst_n;
    pkt_fmt_pkg::beat_t ts_data;
    logic               ts_data_en;
    pkt_fmt_pkg::desc_t ts_val;
    logic               ts_val_en;
    logic               ts_alf;
    pkt_fmt_pkg::beat_t be_data;
    logic               be_data_en;
    pkt_fmt_pkg::desc_t be_val;
    logic               be_val_en;
    logic               be_alf;
    pkt_fmt_pkg::beat_t out_data;
    logic               out_data_en;
    pkt_fmt_pkg::desc_t out_val;
    logic               out_val_en;
    logic               pkt_alf;
    int                 chk_errors;
    int                 tb_errors = 0;
    int                 cycles = 0;
    int                 limit = 200;
    logic [31:0]        rng = 32'd85037;
    pkt_fmt_pkg::beat_t frame_beat [NROWS][queue_pkg::BEAT_DEPTH];

    egress_top DUT (
        .i_sys_clk (sys_clk), .i_sys_rst_n (sys_rst_n),
        .i_ts_pkt_data (ts_data), .i_ts_pkt_data_en (ts_data_en),
        .i_ts_pkt_val (ts_val), .i_ts_pkt_val_en (ts_val_en), .o_ts_pkt_data_alf (ts_alf),
        .i_be_pkt_data (be_data), .i_be_pkt_data_en (be_data_en),
        .i_be_pkt_val (be_val), .i_be_pkt_val_en (be_val_en), .o_be_pkt_data_alf (be_alf),
        .o_pkt_data (out_data), .o_pkt_data_en (out_data_en),
        .o_pkt_val (out_val), .o_pkt_val_en (out_val_en), .i_pkt_data_alf (pkt_alf)
    );

    egress_checker u_checker (
        .i_sys_clk (sys_clk), .i_sys_rst_n (sys_rst_n),
        .i_pkt_data (out_data), .i_pkt_data_en (out_data_en),
        .i_pkt_val (out_val), .i_pkt_val_en (out_val_en), .o_errors (chk_errors)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic pkt_fmt_pkg::desc_t make_desc(input int r);
        pkt_fmt_pkg::desc_t d;
        d.valid = tbl_valid[r];
        d.len   = 15'(tbl_beats[r] * 4);                   // bytes, four per beat
        return d;
    endfunction

    // inputs change 2 ns after the edge, strobes last one cycle
    task automatic next_cycle();
        @(posedge sys_clk);
        #2;
        ts_data_en = 1'b0;
        ts_val_en  = 1'b0;
        be_data_en = 1'b0;
        be_val_en  = 1'b0;
    endtask

    task automatic write_beats(input int r);
        pkt_fmt_pkg::beat_t b;
        for (int i = 0; i < tbl_beats[r]; i++) begin
            rng      = xorshift32(rng);
            b.tag    = (i == 0) ? pkt_fmt_pkg::TAG_HEAD :
                       (i == tbl_beats[r] - 1) ? pkt_fmt_pkg::TAG_TAIL : pkt_fmt_pkg::TAG_BODY;
            b.vbytes = 2'd0;
            b.data   = rng;
            frame_beat[r][i] = b;
            next_cycle();
            if (tbl_cls[r] == TS) begin
                ts_data    = b;
                ts_data_en = 1'b1;
            end else begin
                be_data    = b;
                be_data_en = 1'b1;
            end
        end
    endtask

    task automatic drive_desc(input int r);
        if (tbl_cls[r] == TS) begin
            ts_val    = make_desc(r);
            ts_val_en = 1'b1;
        end else begin
            be_val    = make_desc(r);
            be_val_en = 1'b1;
        end
    endtask

    task automatic queue_expected(input int r);
        if (tbl_fwd[r]) begin
            for (int i = 0; i < tbl_beats[r]; i++) begin
                u_checker.expect_beat(tbl_name[r], frame_beat[r][i]);
            end
            u_checker.expect_desc(tbl_name[r], make_desc(r));
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %0b actual %0b", name, what, exp, act);
            tb_errors++;
        end
    endtask

    initial begin
        int held;
        int drain;
        bit stalled;
        held = -1;
        for (int r = 0; r < NROWS; r++) begin
            limit += tbl_beats[r] * 4;
        end
        sys_rst_n  = 1'b0;
        ts_data    = '0;
        ts_data_en = 1'b0;
        ts_val     = '0;
        ts_val_en  = 1'b0;
        be_data    = '0;
        be_data_en = 1'b0;
        be_val     = '0;
        be_val_en  = 1'b0;
        pkt_alf    = 1'b0;
        repeat (16) @(posedge sys_clk);
        #2 sys_rst_n = 1'b1;
        for (int r = 0; r < NROWS; r++) begin
            next_cycle();
            pkt_alf = tbl_alf[r];
            write_beats(r);
            if (tbl_hold[r]) begin
                held = r;                                  // descriptor goes out with the next row's
                continue;
            end
            // ts goes out first when two descriptors land together
            if (held >= 0 && tbl_cls[held] == TS) queue_expected(held);
            queue_expected(r);
            if (held >= 0 && tbl_cls[held] != TS) queue_expected(held);
            next_cycle();
            drive_desc(r);
            if (held >= 0) drive_desc(held);
            stalled = tbl_fwd[r] && tbl_alf[r];
            if (stalled) begin
                repeat (HOLD_CYC) begin
                    next_cycle();
                    check_bit(tbl_name[r], "output beat under back-pressure", 1'b0, out_data_en);
                end
                check_bit(tbl_name[r], "ts almost-full", tbl_beats[r] >= queue_pkg::BEAT_AF_LEVEL,
                          ts_alf);
                check_bit(tbl_name[r], "be almost-full", 1'b0, be_alf);
                pkt_alf = 1'b0;
            end
            if (u_checker.pending_frames() != 0) begin
                while (u_checker.pending_frames() != 0) next_cycle();
            end else begin
                drain = tbl_beats[r] + ((held >= 0) ? tbl_beats[held] : 0) + 4;
                repeat (drain) next_cycle();               // dropped frames drain one beat per cycle
            end
            repeat (3) next_cycle();
            if (stalled) check_bit(tbl_name[r], "ts almost-full after drain", 1'b0, ts_alf);
            held = -1;
        end
        u_checker.finish_check();
        next_cycle();
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
